//--- list.f
verilog/cache_cfg_pkg.sv
verilog/cache_msg_pkg.sv
verilog/bank_fifo.sv
verilog/bank_tag_stage.sv
verilog/bank_data_stage.sv
verilog/cache_bank.sv
verification/cache_bank_checker.sv
verification/cache_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache bank testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f list.f \
    --top-module cache_bank_tb \
    -o sim_cache_bank > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_cache_bank > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status, see sim.log"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    echo "test failed, see sim.log"
    exit 1
fi

echo "test passed"
exit 0

//--- verification/cache_bank_checker.sv
`timescale 1ns/1ps

module cache_bank_checker (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     core_rsp_valid,
    input cache_msg_pkg::core_rsp_t core_rsp,
    input logic                     core_rsp_ready,
    input logic                     mem_req_valid,
    input cache_msg_pkg::mem_req_t  mem_req,
    input logic                     mem_req_ready,
    input logic                     mem_rsp_valid,
    input logic                     mem_rsp_ready
);

    // reads sent to memory and not yet answered
    int rd_outstanding;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_outstanding <= 0;
        end else begin
            rd_outstanding <= rd_outstanding
                + int'(mem_req_valid && mem_req_ready && !mem_req.rw)
                - int'(mem_rsp_valid && mem_rsp_ready);
        end
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !core_rsp_valid && !mem_req_valid)
        else $error("output valid during reset");

    a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
        else $error("core_rsp changed before transfer");

    a_mem_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("mem_req changed before transfer");

    a_no_stray_fill: assert property (@(posedge clk) disable iff (!arst_n)
        mem_rsp_valid |-> rd_outstanding > 0)
        else $error("mem_rsp without outstanding read");

endmodule

bind cache_bank cache_bank_checker u_checker (.*);

//--- verification/cache_bank_tb.sv
`timescale 1ns/1ps

module cache_bank_tb;

    localparam int NUM_LINES = 16;
    localparam int N_ENTRIES = 13;
    localparam int N_BURST   = 12;
    localparam int N_LINES_MEM = 1 << cache_cfg_pkg::LINE_ADDR_WIDTH;
    localparam int N_WORDS     = 1 << cache_cfg_pkg::ADDR_WIDTH;

    // op, word addr, byteen, data, req_tag, memory read expected
    typedef struct packed {
        logic        rw;
        logic [11:0] addr;
        logic [3:0]  byteen;
        logic [31:0] data;
        logic [3:0]  req_tag;
        logic        exp_rd;
    } entry_t;

    logic                     clk;
    logic                     arst_n;
    logic                     core_req_valid;
    cache_msg_pkg::core_req_t core_req;
    logic                     core_req_ready;
    logic                     core_rsp_valid;
    cache_msg_pkg::core_rsp_t core_rsp;
    logic                     core_rsp_ready;
    logic                     mem_req_valid;
    cache_msg_pkg::mem_req_t  mem_req;
    logic                     mem_req_ready;
    logic                     mem_rsp_valid;
    cache_msg_pkg::mem_rsp_t  mem_rsp;
    logic                     mem_rsp_ready;

    entry_t      table_mem [N_ENTRIES];
    logic [127:0] mem_lines [N_LINES_MEM];
    logic [31:0] ref_words [N_WORDS];

    cache_msg_pkg::core_rsp_t rsp_seen [$];
    cache_msg_pkg::mem_req_t  mreq_seen [$];
    cache_msg_pkg::core_rsp_t burst_exp [$];

    logic         rand_ready;
    logic         rd_pending;
    logic         rsp_taken;
    int           rsp_delay;
    logic [127:0] rsp_line;

    cache_bank #(
        .NUM_LINES  (NUM_LINES),
        .CREQ_DEPTH (4),
        .CRSP_DEPTH (4),
        .MREQ_DEPTH (4)
    ) u_dut (.*);

    always #50 clk = ~clk;

    task automatic fail_check(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input cache_msg_pkg::core_rsp_t got,
                             input cache_msg_pkg::core_rsp_t exp);
        if (got !== exp) begin
            fail_check($sformatf("core_rsp data %h tag %h, expected data %h tag %h",
                got.data, got.req_tag, exp.data, exp.req_tag));
        end
    endtask

    task automatic check_mem_req(input cache_msg_pkg::mem_req_t got,
                                 input cache_msg_pkg::mem_req_t exp);
        if (got !== exp) begin
            fail_check($sformatf("mem_req %h, expected %h", got, exp));
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  byteen);
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (byteen[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // memory model and output monitor, sampled at the rising edge
    always @(posedge clk) begin
        if (arst_n && mem_req_valid && mem_req_ready) begin
            mreq_seen.push_back(mem_req);
            if (mem_req.rw) begin
                mem_lines[mem_req.addr][mem_req.wsel*32 +: 32] = merge_bytes(
                    mem_lines[mem_req.addr][mem_req.wsel*32 +: 32],
                    mem_req.data, mem_req.byteen);
            end else begin
                rsp_line   = mem_lines[mem_req.addr];
                rsp_delay  = $urandom_range(0, 5);
                rd_pending = 1'b1;
            end
        end
        if (arst_n && core_rsp_valid && core_rsp_ready) begin
            rsp_seen.push_back(core_rsp);
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            rsp_taken = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (mem_rsp_valid && rsp_taken) begin
            mem_rsp_valid = 1'b0;
            rsp_taken     = 1'b0;
        end
        if (rd_pending && !mem_rsp_valid) begin
            if (rsp_delay == 0) begin
                mem_rsp       = rsp_line;
                mem_rsp_valid = 1'b1;
                rd_pending    = 1'b0;
            end else begin
                rsp_delay--;
            end
        end
        core_rsp_ready = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
        mem_req_ready  = rand_ready ? 1'($urandom_range(0, 1)) : 1'b1;
    end

    task automatic send_req(input logic rw, input logic [11:0] addr,
                            input logic [3:0] byteen, input logic [31:0] data,
                            input logic [3:0] req_tag);
        @(negedge clk);
        core_req_valid   = 1'b1;
        core_req.rw      = rw;
        core_req.addr    = addr;
        core_req.byteen  = byteen;
        core_req.data    = data;
        core_req.req_tag = req_tag;
        do @(posedge clk); while (!core_req_ready);
        @(negedge clk);
        core_req_valid = 1'b0;
    endtask

    task automatic run_entry(input entry_t e);
        cache_msg_pkg::core_rsp_t got_rsp;
        cache_msg_pkg::core_rsp_t exp_rsp;
        cache_msg_pkg::mem_req_t  got_req;
        cache_msg_pkg::mem_req_t  exp_req;
        send_req(e.rw, e.addr, e.byteen, e.data, e.req_tag);
        if (e.rw) begin
            while (mreq_seen.size() == 0) @(negedge clk);
            got_req = mreq_seen.pop_front();
            exp_req = '{1'b1, e.addr[11:2], e.addr[1:0], e.byteen, e.data};
            check_mem_req(got_req, exp_req);
            ref_words[e.addr] = merge_bytes(ref_words[e.addr], e.data, e.byteen);
        end else begin
            while (rsp_seen.size() == 0) @(negedge clk);
            got_rsp = rsp_seen.pop_front();
            exp_rsp.data    = ref_words[e.addr];
            exp_rsp.req_tag = e.req_tag;
            check_rsp(got_rsp, exp_rsp);
            if (mreq_seen.size() != int'(e.exp_rd)) begin
                fail_check($sformatf("%0d memory reads for addr %h, expected %0d",
                    mreq_seen.size(), e.addr, e.exp_rd));
            end
            if (e.exp_rd) begin
                got_req = mreq_seen.pop_front();
                exp_req = '{1'b0, e.addr[11:2], 2'b00, 4'h0, 32'h0};
                if (got_req.rw !== 1'b0 || got_req.addr !== exp_req.addr) begin
                    check_mem_req(got_req, exp_req);
                end
            end
        end
    endtask

    initial begin
        #((N_ENTRIES + N_BURST) * 200 * 100 + 2000);
        $display("timeout: the bank stopped answering requests");
        $display("Simulation FAILED");
        $fatal(1);
    end

    initial begin
        logic [11:0]              addr;
        cache_msg_pkg::core_rsp_t exp_rsp;
        cache_msg_pkg::mem_req_t  got_req;
        void'($urandom(16007));
        clk = 1'b0;
        arst_n = 1'b0;
        core_req_valid = 1'b0;
        core_req = '0;
        core_rsp_ready = 1'b1;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        rand_ready = 1'b0;
        rd_pending = 1'b0;
        rsp_taken = 1'b0;
        rsp_delay = 0;
        rsp_line = '0;
        for (int l = 0; l < N_LINES_MEM; l++) begin
            for (int w = 0; w < 4; w++) begin
                mem_lines[l][w*32 +: 32] = $urandom;
                ref_words[l*4 + w] = mem_lines[l][w*32 +: 32];
            end
        end

        // line 0x10 and 0x80 share index 0, 0x11 and 0x21 share index 1
        table_mem[0]  = '{1'b0, 12'h040, 4'h0, 32'h0,         4'd1,  1'b1};
        table_mem[1]  = '{1'b0, 12'h043, 4'h0, 32'h0,         4'd2,  1'b0};
        table_mem[2]  = '{1'b1, 12'h041, 4'h5, 32'hA1B2C3D4, 4'd3,  1'b0};
        table_mem[3]  = '{1'b0, 12'h041, 4'h0, 32'h0,         4'd4,  1'b0};
        table_mem[4]  = '{1'b1, 12'h200, 4'hF, 32'h12345678, 4'd5,  1'b0};
        table_mem[5]  = '{1'b0, 12'h200, 4'h0, 32'h0,         4'd6,  1'b1};
        table_mem[6]  = '{1'b0, 12'h202, 4'h0, 32'h0,         4'd7,  1'b0};
        table_mem[7]  = '{1'b0, 12'h044, 4'h0, 32'h0,         4'd8,  1'b1};
        table_mem[8]  = '{1'b0, 12'h084, 4'h0, 32'h0,         4'd9,  1'b1};
        table_mem[9]  = '{1'b0, 12'h045, 4'h0, 32'h0,         4'd10, 1'b1};
        table_mem[10] = '{1'b1, 12'h300, 4'h8, 32'hDEADBEEF, 4'd11, 1'b0};
        table_mem[11] = '{1'b0, 12'h300, 4'h0, 32'h0,         4'd12, 1'b1};
        table_mem[12] = '{1'b0, 12'h040, 4'h0, 32'h0,         4'd13, 1'b1};

        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < N_ENTRIES; i++) begin
            run_entry(table_mem[i]);
        end

        // back to back reads under random back-pressure
        rand_ready = 1'b1;
        for (int i = 0; i < N_BURST; i++) begin
            addr = 12'($urandom_range(12'h040, 12'h0BF));
            exp_rsp.data    = ref_words[addr];
            exp_rsp.req_tag = 4'(i);
            burst_exp.push_back(exp_rsp);
            send_req(1'b0, addr, 4'h0, 32'h0, 4'(i));
        end
        while (rsp_seen.size() < N_BURST) @(negedge clk);
        for (int i = 0; i < N_BURST; i++) begin
            check_rsp(rsp_seen.pop_front(), burst_exp.pop_front());
        end
        while (mreq_seen.size() > 0) begin
            got_req = mreq_seen.pop_front();
            if (got_req.rw !== 1'b0) begin
                fail_check("write mem_req seen during read burst");
            end
        end
        rand_ready = 1'b0;
        repeat (20) @(negedge clk);

        if (rsp_seen.size() == 0 && mreq_seen.size() == 0 && !mem_rsp_valid) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("extra responses or memory requests at the end of the run");
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

endmodule

//--- verilog/bank_data_stage.sv
`timescale 1ns/1ps

module bank_data_stage #(
    parameter int NUM_LINES = 16
) (
    input  logic                     clk,
    input  logic                     arst_n,

    input  cache_msg_pkg::bank_op_t  op_st1,
    output logic                     stall,

    output logic                     crsp_valid,
    output cache_msg_pkg::core_rsp_t crsp,
    input  logic                     crsp_ready,

    output logic                     mreq_valid,
    output cache_msg_pkg::mem_req_t  mreq,
    input  logic                     mreq_ready
);

    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int IDX_W    = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int WW       = cache_cfg_pkg::WORD_WIDTH;

    logic [cache_cfg_pkg::LINE_WIDTH-1:0] line_mem [NUM_LINES];

    logic [cache_cfg_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
    logic [cache_cfg_pkg::WSEL_BITS-1:0]       wsel;
    logic [IDX_W-1:0]                          idx;
    logic [cache_cfg_pkg::LINE_WIDTH-1:0]      rd_line;
    logic [cache_cfg_pkg::LINE_WIDTH-1:0]      src_line;
    logic [cache_cfg_pkg::LINE_WIDTH-1:0]      wr_line;

    logic is_read;
    logic write_hit;
    logic crsp_push;
    logic mreq_push;
    logic line_we;

    assign line_addr = op_st1.addr[cache_cfg_pkg::ADDR_WIDTH-1:cache_cfg_pkg::WSEL_BITS];
    assign wsel      = op_st1.addr[cache_cfg_pkg::WSEL_BITS-1:0];
    assign idx       = IDX_W'(line_addr % NUM_LINES);
    assign rd_line   = line_mem[idx];

    assign is_read   = !op_st1.is_fill && !op_st1.rw;
    assign write_hit = !op_st1.is_fill && op_st1.rw && op_st1.hit;

    // read hits and fills answer the core, misses and writes go to memory
    assign crsp_push = op_st1.valid && (op_st1.is_fill || (is_read && op_st1.hit));
    assign mreq_push = op_st1.valid && !op_st1.is_fill && (op_st1.rw || !op_st1.hit);

    assign stall = (crsp_push && !crsp_ready) || (mreq_push && !mreq_ready);

    // fill data bypasses the array for the waiting read
    assign src_line = op_st1.is_fill ? op_st1.fill_line : rd_line;

    assign crsp_valid   = crsp_push;
    assign crsp.data    = src_line[int'(wsel) * WW +: WW];
    assign crsp.req_tag = op_st1.req_tag;

    assign mreq_valid  = mreq_push;
    assign mreq.rw     = op_st1.rw;
    assign mreq.addr   = line_addr;
    assign mreq.wsel   = wsel;
    assign mreq.byteen = op_st1.byteen;
    assign mreq.data   = op_st1.data;

    // byte merge of the write word into the stored line
    always_comb begin
        wr_line = rd_line;
        if (op_st1.is_fill) begin
            wr_line = op_st1.fill_line;
        end else begin
            for (int b = 0; b < cache_cfg_pkg::WORD_BYTES; b++) begin
                if (op_st1.byteen[b]) begin
                    wr_line[int'(wsel) * WW + b * 8 +: 8] = op_st1.data[b * 8 +: 8];
                end
            end
        end
    end

    // array holds still while reset is asserted
    assign line_we = arst_n && op_st1.valid && !stall && (op_st1.is_fill || write_hit);

    always_ff @(posedge clk) begin
        if (line_we) begin
            line_mem[idx] <= wr_line;
        end
    end

endmodule

//--- verilog/bank_fifo.sv
`timescale 1ns/1ps

module bank_fifo #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,

    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,

    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = slots[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_data;
        end
    end

endmodule

//--- verilog/bank_tag_stage.sv
`timescale 1ns/1ps

module bank_tag_stage #(
    parameter int NUM_LINES = 16
) (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     creq_valid,
    input  cache_msg_pkg::core_req_t creq,
    output logic                     creq_ready,

    input  logic                     mem_rsp_valid,
    input  cache_msg_pkg::mem_rsp_t  mem_rsp,
    output logic                     mem_rsp_ready,

    input  logic                     stall,
    output cache_msg_pkg::bank_op_t  op_st1
);

    localparam int IDX_BITS = $clog2(NUM_LINES);
    localparam int IDX_W    = (IDX_BITS > 0) ? IDX_BITS : 1;
    localparam int TAG_W    = (cache_cfg_pkg::LINE_ADDR_WIDTH > IDX_BITS) ?
                              cache_cfg_pkg::LINE_ADDR_WIDTH - IDX_BITS : 1;

    logic [TAG_W-1:0]     tag_array [NUM_LINES];
    logic [NUM_LINES-1:0] line_valid;

    cache_msg_pkg::bank_op_t op_in;
    cache_msg_pkg::bank_op_t op_st0;
    cache_msg_pkg::bank_op_t op_lookup;

    logic [IDX_W-1:0] idx_st0;
    logic [IDX_W-1:0] idx_pend;
    logic             hit_st0;
    logic             rd_miss_st0;
    logic             mem_fire;
    logic             creq_fire;

    // the single outstanding read miss
    logic                                    pend_valid;
    logic [cache_cfg_pkg::ADDR_WIDTH-1:0]    pend_addr;
    logic [cache_cfg_pkg::REQ_TAG_WIDTH-1:0] pend_tag;

    function automatic logic [IDX_W-1:0] line_index(
        input logic [cache_cfg_pkg::ADDR_WIDTH-1:0] addr
    );
        logic [cache_cfg_pkg::LINE_ADDR_WIDTH-1:0] line;
        line = addr[cache_cfg_pkg::ADDR_WIDTH-1:cache_cfg_pkg::WSEL_BITS];
        return IDX_W'(line % NUM_LINES);
    endfunction

    function automatic logic [TAG_W-1:0] line_tag(
        input logic [cache_cfg_pkg::ADDR_WIDTH-1:0] addr
    );
        logic [cache_cfg_pkg::LINE_ADDR_WIDTH-1:0] line;
        line = addr[cache_cfg_pkg::ADDR_WIDTH-1:cache_cfg_pkg::WSEL_BITS];
        return TAG_W'(line / NUM_LINES);
    endfunction

    // fills win over core requests
    assign mem_rsp_ready = !stall;
    assign mem_fire      = mem_rsp_valid && !stall;
    assign creq_ready    = !stall && !mem_rsp_valid && !pend_valid && !rd_miss_st0;
    assign creq_fire     = creq_valid && creq_ready;

    assign idx_st0     = line_index(op_st0.addr);
    assign idx_pend    = line_index(pend_addr);
    assign hit_st0     = line_valid[idx_st0] && (tag_array[idx_st0] == line_tag(op_st0.addr));
    assign rd_miss_st0 = op_st0.valid && !op_st0.is_fill && !op_st0.rw && !hit_st0;

    always_comb begin
        op_in = '0;
        if (mem_fire) begin
            op_in.valid     = 1'b1;
            op_in.is_fill   = 1'b1;
            op_in.addr      = pend_addr;
            op_in.req_tag   = pend_tag;
            op_in.fill_line = mem_rsp;
        end else if (creq_fire) begin
            op_in.valid   = 1'b1;
            op_in.rw      = creq.rw;
            op_in.addr    = creq.addr;
            op_in.byteen  = creq.byteen;
            op_in.data    = creq.data;
            op_in.req_tag = creq.req_tag;
        end
    end

    always_comb begin
        op_lookup     = op_st0;
        op_lookup.hit = hit_st0;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_st0 <= '0;
            op_st1 <= '0;
        end else if (!stall) begin
            op_st0 <= op_in;
            op_st1 <= op_lookup;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_valid <= 1'b0;
        end else if (mem_fire) begin
            pend_valid <= 1'b0;
        end else if (rd_miss_st0 && !stall) begin
            pend_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_miss_st0 && !stall) begin
            pend_addr <= op_st0.addr;
            pend_tag  <= op_st0.req_tag;
        end
    end

    // tag is installed as the fill enters stage 0
    always_ff @(posedge clk) begin
        if (mem_fire) begin
            tag_array[idx_pend] <= line_tag(pend_addr);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line_valid <= '0;
        end else if (mem_fire) begin
            line_valid[idx_pend] <= 1'b1;
        end
    end

endmodule

//--- verilog/cache_bank.sv
`timescale 1ns/1ps

module cache_bank #(
    parameter int NUM_LINES  = 16,
    parameter int CREQ_DEPTH = 4,
    parameter int CRSP_DEPTH = 4,
    parameter int MREQ_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     core_req_valid,
    input  cache_msg_pkg::core_req_t core_req,
    output logic                     core_req_ready,

    output logic                     core_rsp_valid,
    output cache_msg_pkg::core_rsp_t core_rsp,
    input  logic                     core_rsp_ready,

    output logic                     mem_req_valid,
    output cache_msg_pkg::mem_req_t  mem_req,
    input  logic                     mem_req_ready,

    input  logic                     mem_rsp_valid,
    input  cache_msg_pkg::mem_rsp_t  mem_rsp,
    output logic                     mem_rsp_ready
);

    logic                     creq_valid;
    cache_msg_pkg::core_req_t creq;
    logic                     creq_ready;

    cache_msg_pkg::bank_op_t  op_st1;
    logic                     stall;

    logic                     crsp_valid;
    cache_msg_pkg::core_rsp_t crsp;
    logic                     crsp_ready;

    logic                     mreq_valid;
    cache_msg_pkg::mem_req_t  mreq;
    logic                     mreq_ready;

    bank_fifo #(
        .DEPTH     (CREQ_DEPTH),
        .payload_t (cache_msg_pkg::core_req_t)
    ) u_creq_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (core_req_valid),
        .in_data   (core_req),
        .in_ready  (core_req_ready),
        .out_valid (creq_valid),
        .out_data  (creq),
        .out_ready (creq_ready)
    );

    bank_tag_stage #(
        .NUM_LINES (NUM_LINES)
    ) u_tag_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .creq_valid    (creq_valid),
        .creq          (creq),
        .creq_ready    (creq_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .stall         (stall),
        .op_st1        (op_st1)
    );

    bank_data_stage #(
        .NUM_LINES (NUM_LINES)
    ) u_data_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .op_st1     (op_st1),
        .stall      (stall),
        .crsp_valid (crsp_valid),
        .crsp       (crsp),
        .crsp_ready (crsp_ready),
        .mreq_valid (mreq_valid),
        .mreq       (mreq),
        .mreq_ready (mreq_ready)
    );

    bank_fifo #(
        .DEPTH     (CRSP_DEPTH),
        .payload_t (cache_msg_pkg::core_rsp_t)
    ) u_crsp_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (crsp_valid),
        .in_data   (crsp),
        .in_ready  (crsp_ready),
        .out_valid (core_rsp_valid),
        .out_data  (core_rsp),
        .out_ready (core_rsp_ready)
    );

    bank_fifo #(
        .DEPTH     (MREQ_DEPTH),
        .payload_t (cache_msg_pkg::mem_req_t)
    ) u_mreq_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mreq_valid),
        .in_data   (mreq),
        .in_ready  (mreq_ready),
        .out_valid (mem_req_valid),
        .out_data  (mem_req),
        .out_ready (mem_req_ready)
    );

endmodule

//--- verilog/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // word geometry
    localparam int WORD_WIDTH = 32;
    localparam int WORD_BYTES = 4;

    // line geometry
    localparam int WORDS_PER_LINE = 4;
    localparam int WSEL_BITS = 2;
    localparam int LINE_WIDTH = WORDS_PER_LINE * WORD_WIDTH;

    // word address, split into line address and word select
    localparam int ADDR_WIDTH = 12;
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - WSEL_BITS;

    localparam int REQ_TAG_WIDTH = 4;

endpackage

//--- verilog/cache_msg_pkg.sv
package cache_msg_pkg;

    typedef struct packed {
        logic                                     rw;
        logic [cache_cfg_pkg::ADDR_WIDTH-1:0]     addr;
        logic [cache_cfg_pkg::WORD_BYTES-1:0]     byteen;
        logic [cache_cfg_pkg::WORD_WIDTH-1:0]     data;
        logic [cache_cfg_pkg::REQ_TAG_WIDTH-1:0]  req_tag;
    } core_req_t;

    typedef struct packed {
        logic [cache_cfg_pkg::WORD_WIDTH-1:0]     data;
        logic [cache_cfg_pkg::REQ_TAG_WIDTH-1:0]  req_tag;
    } core_rsp_t;

    // line addressed; wsel, byteen and data only matter for writes
    typedef struct packed {
        logic                                       rw;
        logic [cache_cfg_pkg::LINE_ADDR_WIDTH-1:0]  addr;
        logic [cache_cfg_pkg::WSEL_BITS-1:0]        wsel;
        logic [cache_cfg_pkg::WORD_BYTES-1:0]       byteen;
        logic [cache_cfg_pkg::WORD_WIDTH-1:0]       data;
    } mem_req_t;

    typedef logic [cache_cfg_pkg::LINE_WIDTH-1:0] mem_rsp_t;

    // item moving through stage 0 and stage 1
    typedef struct packed {
        logic                                     valid;
        logic                                     is_fill;
        logic                                     rw;
        logic                                     hit;
        logic [cache_cfg_pkg::ADDR_WIDTH-1:0]     addr;
        logic [cache_cfg_pkg::WORD_BYTES-1:0]     byteen;
        logic [cache_cfg_pkg::WORD_WIDTH-1:0]     data;
        logic [cache_cfg_pkg::REQ_TAG_WIDTH-1:0]  req_tag;
        logic [cache_cfg_pkg::LINE_WIDTH-1:0]     fill_line;
    } bank_op_t;

endpackage
